// ==== csr_file.f ====
source/csr_pkg.sv
source/csr_masked_reg.sv
source/csr_timer.sv
source/csr_priv_state.sv
source/csr_read_mux.sv
source/csr_file.sv
bench/tb_clock.sv
bench/csr_file_tb.sv

// ==== Bender.yml ====
package:
  name: csr_file

sources:
  - source/csr_pkg.sv
  - source/csr_masked_reg.sv
  - source/csr_timer.sv
  - source/csr_priv_state.sv
  - source/csr_read_mux.sv
  - source/csr_file.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/csr_file_tb.sv

// ==== bench/csr_file_tb.sv ====
`timescale 1ns/1ps

module csr_file_tb
    import csr_pkg::*;
();

    localparam int NUM_PORTS  = 2;
    localparam int HWI_BITS   = 8;
    localparam int WAIT_LIMIT = 64;

    logic                clk;
    logic                rst;
    csr_write_t          csr_wr;
    exc_req_t            exc;
    logic [HWI_BITS-1:0] hwi;
    csr_read_req_t       rd_req [NUM_PORTS];
    word_t               rd_data [NUM_PORTS];
    priv_view_t          priv;

    integer    seed;
    word_t     model_reg [16384]; // Expected contents by CSR number
    csr_addr_t kept_addrs [$];
    csr_addr_t writable_addrs [$];

    tb_clock clock_inst (.clk(clk), .rst(rst));

    csr_file #(
        .NUM_READ_PORTS(NUM_PORTS),
        .HWI_COUNT(HWI_BITS),
        .TIMER_BITS(32)
    ) csr_file_inst (
        .clk(clk), .rst(rst), .csr_wr(csr_wr), .exc(exc), .hwi(hwi),
        .rd_req(rd_req), .rd_data(rd_data), .priv(priv)
    );

    function automatic word_t write_mask(input csr_addr_t a);
        case (a)
            CSR_CRMD:   return CRMD_WMASK;
            CSR_PRMD:   return PRMD_WMASK;
            CSR_ECFG:   return ECFG_WMASK;
            CSR_ESTAT:  return ESTAT_WMASK;
            CSR_EENTRY: return EENTRY_WMASK;
            CSR_TVAL, CSR_TICLR, CSR_CPUID: return '0; // Nothing stored by software
            default:    return FULL_WMASK;
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp)
            else fail_run($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got));
    endtask

    task automatic check_priv();
        check_word("priv.crmd", priv.crmd, model_reg[CSR_CRMD]);
        check_word("priv.era", priv.era, model_reg[CSR_ERA]);
        check_word("priv.eentry", priv.eentry, model_reg[CSR_EENTRY]);
        check_word("priv.ecfg", priv.ecfg, model_reg[CSR_ECFG]);
        check_word("priv.estat", priv.estat, model_reg[CSR_ESTAT]);
    endtask

    // Both ports in the same cycle, plus the priv view
    task automatic read_check(input logic en0, input csr_addr_t a0,
                              input logic en1, input csr_addr_t a1);
        @(negedge clk);
        rd_req[0] = {en0, a0};
        rd_req[1] = {en1, a1};
        #1;
        check_word($sformatf("rd_data[0] at 0x%h", a0), rd_data[0], en0 ? model_reg[a0] : '0);
        check_word($sformatf("rd_data[1] at 0x%h", a1), rd_data[1], en1 ? model_reg[a1] : '0);
        check_priv();
    endtask

    task automatic sample_port(input csr_addr_t a, output word_t v);
        @(negedge clk);
        rd_req[0] = {1'b1, a};
        #1;
        v = rd_data[0];
    endtask

    task automatic drive_write(input csr_addr_t a, input word_t d);
        word_t m;
        m = write_mask(a);
        @(negedge clk);
        csr_wr = {1'b1, a, d};
        @(negedge clk);
        csr_wr.en = 1'b0;
        model_reg[a] = (model_reg[a] & ~m) | (d & m);
        if (a == CSR_TICLR && d[0]) begin
            model_reg[CSR_ESTAT][ESTAT_TI] = 1'b0;
        end
    endtask

    // Entry with an ERA write in the same cycle, which must be lost
    task automatic take_exception(input ecode_t code);
        word_t pc;
        word_t r;
        word_t crmd;
        pc = $random(seed);
        r = $random(seed);
        crmd = model_reg[CSR_CRMD];
        @(negedge clk);
        exc = {1'b1, 1'b0, code, r[8:0], pc};
        csr_wr = {1'b1, CSR_ERA, ~pc};
        @(negedge clk);
        exc = '0;
        csr_wr.en = 1'b0;
        model_reg[CSR_PRMD][2:0] = crmd[2:0]; // PPLV and PIE
        model_reg[CSR_CRMD][2:0] = 3'b000;
        if (code == ECODE_TLBR) begin
            model_reg[CSR_CRMD][CRMD_DA] = 1'b1;
            model_reg[CSR_CRMD][CRMD_PG] = 1'b0;
        end
        model_reg[CSR_ERA] = pc;
        model_reg[CSR_ESTAT][ESTAT_ECODE +: 6] = code;
        model_reg[CSR_ESTAT][ESTAT_ESUB +: 9] = r[8:0];
    endtask

    task automatic return_from_exception();
        @(negedge clk);
        exc.ertn = 1'b1;
        @(negedge clk);
        exc.ertn = 1'b0;
        model_reg[CSR_CRMD][2:0] = model_reg[CSR_PRMD][2:0];
        if (model_reg[CSR_ESTAT][ESTAT_ECODE +: 6] == ECODE_TLBR) begin
            model_reg[CSR_CRMD][CRMD_DA] = 1'b0;
            model_reg[CSR_CRMD][CRMD_PG] = 1'b1;
        end
    endtask

    task automatic wait_timer_irq();
        word_t v;
        int    n;
        v = '0;
        for (n = 0; !v[ESTAT_TI]; n++) begin
            if (n == WAIT_LIMIT) begin
                fail_run("Timed out waiting for the timer interrupt bit in ESTAT");
            end
            sample_port(CSR_ESTAT, v);
        end
        model_reg[CSR_ESTAT][ESTAT_TI] = 1'b1;
    endtask

    initial begin
        word_t r;
        word_t v1;
        word_t v2;
        int    n;
        seed = 32'hba4;
        csr_wr = '0;
        exc = '0;
        hwi = '0;
        rd_req[0] = '0;
        rd_req[1] = '0;
        foreach (model_reg[i]) model_reg[i] = '0;
        model_reg[CSR_CRMD] = CRMD_RESET;
        kept_addrs = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_EENTRY, CSR_CPUID,
                       CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG,
                       CSR_TVAL, CSR_TICLR};
        writable_addrs = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_EENTRY, CSR_ESTAT, CSR_ERA,
                           CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID};

        for (n = 0; rst !== 1'b0; n++) begin
            if (n == WAIT_LIMIT) begin
                fail_run("Reset was never released");
            end
            @(negedge clk);
        end

        foreach (kept_addrs[i]) read_check(1'b1, kept_addrs[i], 1'b1, kept_addrs[i]);

        foreach (writable_addrs[i]) begin
            r = $random(seed);
            drive_write(writable_addrs[i], r);
            read_check(1'b1, writable_addrs[i], 1'b1, writable_addrs[i]);
        end
        read_check(1'b0, CSR_SAVE0, 1'b1, 14'h003); // Disabled port, unknown CSR
        read_check(1'b1, CSR_CPUID, 1'b1, CSR_TICLR);

        // Ordinary code leaves DA and PG alone
        drive_write(CSR_CRMD, 32'h0000_0007);
        r = $random(seed);
        take_exception({1'b0, r[4:0]});
        read_check(1'b1, CSR_CRMD, 1'b1, CSR_PRMD);
        read_check(1'b1, CSR_ERA, 1'b1, CSR_ESTAT);
        r = $random(seed);
        drive_write(CSR_PRMD, r);
        return_from_exception();
        read_check(1'b1, CSR_CRMD, 1'b1, CSR_PRMD);

        drive_write(CSR_CRMD, 32'h0000_0017); // PG set, DA clear
        take_exception(ECODE_TLBR);
        read_check(1'b1, CSR_CRMD, 1'b1, CSR_ESTAT);
        read_check(1'b1, CSR_ERA, 1'b1, CSR_PRMD);
        return_from_exception();
        read_check(1'b1, CSR_CRMD, 1'b1, CSR_ESTAT);

        // One-shot, initial value 0x10
        drive_write(CSR_TCFG, 32'h0000_0011);
        sample_port(CSR_TVAL, v1);
        sample_port(CSR_TVAL, v2);
        check_word("rd_data[0] TVAL", v1, 32'h0000_000f);
        check_word("rd_data[0] TVAL", v2, 32'h0000_000e);
        wait_timer_irq();
        model_reg[CSR_TVAL] = '1;
        read_check(1'b1, CSR_TVAL, 1'b1, CSR_TCFG);
        drive_write(CSR_TICLR, 32'h0000_0001);
        read_check(1'b1, CSR_ESTAT, 1'b1, CSR_TICLR);

        // Periodic, initial value 0xc
        drive_write(CSR_TCFG, 32'h0000_000f);
        wait_timer_irq();
        drive_write(CSR_TICLR, 32'h0000_0001);
        read_check(1'b1, CSR_ESTAT, 1'b1, CSR_TCFG);
        wait_timer_irq();
        drive_write(CSR_TCFG, 32'h0000_0000);
        drive_write(CSR_TICLR, 32'h0000_0001);
        model_reg[CSR_TVAL] = '0;
        read_check(1'b1, CSR_TVAL, 1'b1, CSR_ESTAT);

        for (n = 0; n < 8; n++) begin
            r = $random(seed);
            @(negedge clk);
            hwi = r[HWI_BITS-1:0];
            model_reg[CSR_ESTAT][ESTAT_IS_HW +: HWI_BITS] = r[HWI_BITS-1:0];
            read_check(1'b1, CSR_ESTAT, 1'b0, CSR_ESTAT); // One edge later
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== source/csr_file.sv ====
`timescale 1ns/1ps

module csr_file
    import csr_pkg::*;
#(
    parameter int NUM_READ_PORTS = 2,
    parameter int HWI_COUNT      = 8,
    parameter int TIMER_BITS     = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_write_t           csr_wr,
    input  exc_req_t             exc,
    input  logic [HWI_COUNT-1:0] hwi,
    input  csr_read_req_t        rd_req [NUM_READ_PORTS],
    output word_t                rd_data [NUM_READ_PORTS],
    output priv_view_t           priv
);

    word_t crmd;
    word_t prmd;
    word_t estat;
    word_t era;
    word_t ecfg;
    word_t eentry;
    word_t save0;
    word_t save1;
    word_t save2;
    word_t save3;
    word_t tid;
    word_t tcfg;
    word_t tval;
    ecfg_t ecfg_q;
    logic  timer_irq;

    csr_priv_state #(
        .HWI_COUNT(HWI_COUNT)
    ) priv_state_inst (
        .clk(clk), .rst(rst), .csr_wr(csr_wr), .exc(exc), .hwi(hwi),
        .timer_irq(timer_irq), .crmd(crmd), .prmd(prmd), .estat(estat), .era(era)
    );

    csr_timer #(
        .TIMER_BITS(TIMER_BITS)
    ) timer_inst (
        .clk(clk), .rst(rst), .csr_wr(csr_wr),
        .tcfg(tcfg), .tval(tval), .timer_irq(timer_irq)
    );

    csr_masked_reg #(.T(ecfg_t), .ADDR(CSR_ECFG), .WRITE_MASK(ECFG_WMASK), .RESET_VALUE('0))
        ecfg_inst (.clk(clk), .rst(rst), .csr_wr(csr_wr), .value(ecfg_q));

    csr_masked_reg #(.T(word_t), .ADDR(CSR_EENTRY), .WRITE_MASK(EENTRY_WMASK), .RESET_VALUE('0))
        eentry_inst (.clk(clk), .rst(rst), .csr_wr(csr_wr), .value(eentry));

    csr_masked_reg #(.T(word_t), .ADDR(CSR_SAVE0), .WRITE_MASK(FULL_WMASK), .RESET_VALUE('0))
        save0_inst (.clk(clk), .rst(rst), .csr_wr(csr_wr), .value(save0));

    csr_masked_reg #(.T(word_t), .ADDR(CSR_SAVE1), .WRITE_MASK(FULL_WMASK), .RESET_VALUE('0))
        save1_inst (.clk(clk), .rst(rst), .csr_wr(csr_wr), .value(save1));

    csr_masked_reg #(.T(word_t), .ADDR(CSR_SAVE2), .WRITE_MASK(FULL_WMASK), .RESET_VALUE('0))
        save2_inst (.clk(clk), .rst(rst), .csr_wr(csr_wr), .value(save2));

    csr_masked_reg #(.T(word_t), .ADDR(CSR_SAVE3), .WRITE_MASK(FULL_WMASK), .RESET_VALUE('0))
        save3_inst (.clk(clk), .rst(rst), .csr_wr(csr_wr), .value(save3));

    csr_masked_reg #(.T(word_t), .ADDR(CSR_TID), .WRITE_MASK(FULL_WMASK), .RESET_VALUE('0))
        tid_inst (.clk(clk), .rst(rst), .csr_wr(csr_wr), .value(tid));

    // LIE payload widened to a full word
    assign ecfg = {{($bits(word_t) - $bits(ecfg_t)){1'b0}}, ecfg_q};

    csr_read_mux #(
        .NUM_READ_PORTS(NUM_READ_PORTS)
    ) read_mux_inst (
        .rd_req(rd_req),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat), .era(era), .eentry(eentry),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .tid(tid), .tcfg(tcfg), .tval(tval),
        .rd_data(rd_data)
    );

    // View for pipeline control
    assign priv.crmd   = crmd;
    assign priv.era    = era;
    assign priv.eentry = eentry;
    assign priv.ecfg   = ecfg;
    assign priv.estat  = estat;

endmodule

// ==== source/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux
    import csr_pkg::*;
#(
    parameter int NUM_READ_PORTS = 2
) (
    input  csr_read_req_t rd_req [NUM_READ_PORTS],
    input  word_t         crmd,
    input  word_t         prmd,
    input  word_t         ecfg,
    input  word_t         estat,
    input  word_t         era,
    input  word_t         eentry,
    input  word_t         save0,
    input  word_t         save1,
    input  word_t         save2,
    input  word_t         save3,
    input  word_t         tid,
    input  word_t         tcfg,
    input  word_t         tval,
    output word_t         rd_data [NUM_READ_PORTS]
);

    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            rd_data[i] = '0;
            if (rd_req[i].en) begin
                case (rd_req[i].addr)
                    CSR_CRMD:   rd_data[i] = crmd;
                    CSR_PRMD:   rd_data[i] = prmd;
                    CSR_ECFG:   rd_data[i] = ecfg;
                    CSR_ESTAT:  rd_data[i] = estat;
                    CSR_ERA:    rd_data[i] = era;
                    CSR_EENTRY: rd_data[i] = eentry;
                    CSR_SAVE0:  rd_data[i] = save0;
                    CSR_SAVE1:  rd_data[i] = save1;
                    CSR_SAVE2:  rd_data[i] = save2;
                    CSR_SAVE3:  rd_data[i] = save3;
                    CSR_TID:    rd_data[i] = tid;
                    CSR_TCFG:   rd_data[i] = tcfg;
                    CSR_TVAL:   rd_data[i] = tval;
                    // Write-only clear strobe and single core ID
                    CSR_TICLR,
                    CSR_CPUID:  rd_data[i] = '0;
                    default:    rd_data[i] = '0;
                endcase
            end
        end
    end

endmodule

// ==== source/csr_priv_state.sv ====
`timescale 1ns/1ps

module csr_priv_state
    import csr_pkg::*;
#(
    parameter int HWI_COUNT = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_write_t           csr_wr,
    input  exc_req_t             exc,
    input  logic [HWI_COUNT-1:0] hwi,
    input  logic                 timer_irq,
    output word_t                crmd,
    output word_t                prmd,
    output word_t                estat,
    output word_t                era
);

    logic                 crmd_wen;
    logic                 prmd_wen;
    logic                 estat_wen;
    logic                 era_wen;
    logic                 exc_tlbr;
    logic                 ertn_tlbr;
    logic [1:0]           is_sw;
    logic [HWI_COUNT-1:0] is_hw;
    ecode_t               ecode;
    esubcode_t            esubcode;

    assign crmd_wen  = csr_wr.en && (csr_wr.addr == CSR_CRMD);
    assign prmd_wen  = csr_wr.en && (csr_wr.addr == CSR_PRMD);
    assign estat_wen = csr_wr.en && (csr_wr.addr == CSR_ESTAT);
    assign era_wen   = csr_wr.en && (csr_wr.addr == CSR_ERA);

    assign exc_tlbr  = (exc.ecode == ECODE_TLBR);
    assign ertn_tlbr = (ecode == ECODE_TLBR); // Code of the exception being left

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= CRMD_RESET;
        end else if (exc.valid) begin
            crmd[CRMD_PLV +: 2] <= 2'b00;
            crmd[CRMD_IE]       <= 1'b0;
            if (exc_tlbr) begin
                crmd[CRMD_DA] <= 1'b1; // Refill handler runs untranslated
                crmd[CRMD_PG] <= 1'b0;
            end
        end else if (exc.ertn) begin
            crmd[CRMD_PLV +: 2] <= prmd[CRMD_PLV +: 2];
            crmd[CRMD_IE]       <= prmd[CRMD_IE];
            if (ertn_tlbr) begin
                crmd[CRMD_DA] <= 1'b0;
                crmd[CRMD_PG] <= 1'b1;
            end
        end else if (crmd_wen) begin
            crmd <= (crmd & ~CRMD_WMASK) | (csr_wr.data & CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (exc.valid) begin
            prmd[CRMD_PLV +: 2] <= crmd[CRMD_PLV +: 2]; // PPLV
            prmd[CRMD_IE]       <= crmd[CRMD_IE];       // PIE
        end else if (prmd_wen) begin
            prmd <= (prmd & ~PRMD_WMASK) | (csr_wr.data & PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era <= '0;
        end else if (exc.valid) begin
            era <= exc.pc;
        end else if (era_wen) begin
            era <= csr_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            is_sw    <= '0;
            is_hw    <= '0;
            ecode    <= '0;
            esubcode <= '0;
        end else begin
            is_hw <= hwi; // Sampled every cycle
            if (exc.valid) begin
                ecode    <= exc.ecode;
                esubcode <= exc.esubcode;
            end else if (estat_wen) begin
                is_sw <= csr_wr.data[ESTAT_IS_SW +: 2] & ESTAT_WMASK[ESTAT_IS_SW +: 2];
            end
        end
    end

    always_comb begin
        estat                                    = '0;
        estat[ESTAT_IS_SW +: 2]                  = is_sw;
        estat[ESTAT_IS_HW +: HWI_COUNT]          = is_hw;
        estat[ESTAT_TI]                          = timer_irq;
        estat[ESTAT_ECODE +: $bits(ecode_t)]     = ecode;
        estat[ESTAT_ESUB +: $bits(esubcode_t)]   = esubcode;
    end

endmodule

// ==== source/csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer
    import csr_pkg::*;
#(
    parameter int TIMER_BITS = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  csr_write_t csr_wr,
    output word_t      tcfg,
    output word_t      tval,
    output logic       timer_irq
);

    logic [TIMER_BITS-1:0] tcfg_q;
    logic [TIMER_BITS-1:0] tval_q;
    logic                  timer_en;
    logic                  tcfg_wen;
    logic                  ticlr_wen;
    logic                  expire;

    assign tcfg_wen  = csr_wr.en && (csr_wr.addr == CSR_TCFG);
    assign ticlr_wen = csr_wr.en && (csr_wr.addr == CSR_TICLR) && csr_wr.data[0];

    // A fresh TCFG write restarts the count, so no expiry that cycle
    assign expire = timer_en && (tval_q == '0) && !tcfg_wen;

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q   <= '0;
            tval_q   <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_wen) begin
            tcfg_q   <= csr_wr.data[TIMER_BITS-1:0];
            tval_q   <= {csr_wr.data[TIMER_BITS-1:2], 2'b00};
            timer_en <= csr_wr.data[0];
        end else if (timer_en) begin
            if (tval_q != '0) begin
                tval_q <= tval_q - 1'b1;
            end else if (tcfg_q[1]) begin
                tval_q <= {tcfg_q[TIMER_BITS-1:2], 2'b00}; // Periodic reload
            end else begin
                tval_q   <= '1;
                timer_en <= 1'b0;
            end
        end
    end

    // Pending bit, clear beats set
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_irq <= 1'b0;
        end else if (ticlr_wen) begin
            timer_irq <= 1'b0;
        end else if (expire) begin
            timer_irq <= 1'b1;
        end
    end

    assign tcfg = word_t'(tcfg_q);
    assign tval = word_t'(tval_q);

endmodule

// ==== source/csr_masked_reg.sv ====
`timescale 1ns/1ps

module csr_masked_reg
    import csr_pkg::*;
#(
    parameter type       T           = word_t,
    parameter csr_addr_t ADDR        = CSR_SAVE0,
    parameter word_t     WRITE_MASK  = FULL_WMASK,
    parameter word_t     RESET_VALUE = '0
) (
    input  logic       clk,
    input  logic       rst,
    input  csr_write_t csr_wr,
    output T           value
);

    localparam int W = $bits(T);
    localparam logic [W-1:0] MASK = WRITE_MASK[W-1:0];

    logic hit;

    assign hit = csr_wr.en && (csr_wr.addr == ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= T'(RESET_VALUE[W-1:0]);
        end else if (hit) begin
            value <= T'((value & ~MASK) | (csr_wr.data[W-1:0] & MASK)); // Keep read-only bits
        end
    end

endmodule

// ==== source/csr_pkg.sv ====
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // Architectural CSR numbers
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_CPUID  = 14'h020;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    localparam word_t CRMD_WMASK   = 32'h0000_01ff;
    localparam word_t PRMD_WMASK   = 32'h0000_0007;
    localparam word_t ECFG_WMASK   = 32'h0000_1bff; // Bit 10 reserved
    localparam word_t ESTAT_WMASK  = 32'h0000_0003; // Software interrupt bits only
    localparam word_t EENTRY_WMASK = 32'hffff_ffc0;
    localparam word_t FULL_WMASK   = 32'hffff_ffff;

    localparam word_t CRMD_RESET = 32'h0000_0008; // DA set

    localparam ecode_t ECODE_TLBR = 6'h3f;

    // CRMD fields, also used for PPLV/PIE in PRMD
    localparam int CRMD_PLV = 0;
    localparam int CRMD_IE  = 2;
    localparam int CRMD_DA  = 3;
    localparam int CRMD_PG  = 4;

    localparam int ESTAT_IS_SW = 0;
    localparam int ESTAT_IS_HW = 2;
    localparam int ESTAT_TI    = 11;
    localparam int ESTAT_ECODE = 16;
    localparam int ESTAT_ESUB  = 22;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        word_t     data;
    } csr_write_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
    } csr_read_req_t;

    typedef struct packed {
        logic      valid;
        logic      ertn;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     pc;
    } exc_req_t;

    typedef struct packed {
        word_t crmd;
        word_t era;
        word_t eentry;
        word_t ecfg;
        word_t estat;
    } priv_view_t;

    typedef struct packed {
        logic [12:0] lie;
    } ecfg_t;

endpackage
